//--- src/sramSettings.svh
`ifndef SRAM_SETTINGS_SVH
`define SRAM_SETTINGS_SVH

// --------------------
// bus widths
// --------------------
`define SRAM_ADDR_WIDTH 24 // wishbone word address
`define SRAM_DATA_WIDTH 32
`define SRAM_SEL_WIDTH 4   // one select per byte lane

// --------------------
// memory
// --------------------
`define SRAM_DEPTH_LOG2 10 // 1024 words implemented
`define SRAM_CORE_COUNT 2
`define SRAM_WAIT_STATES 2 // busy cycles before completion

`endif

//--- src/sramPkg.sv
`include "sramSettings.svh"

package sramPkg;

	// word address as seen on the wishbone side
	typedef logic [`SRAM_ADDR_WIDTH-1:0] memAddr_t;

	typedef logic [`SRAM_DATA_WIDTH-1:0] memData_t;

	typedef logic [`SRAM_SEL_WIDTH-1:0] byteSel_t; // byte lane enables

	// selects one of the slave ports
	typedef logic [$clog2(`SRAM_CORE_COUNT)-1:0] coreIdx_t;

endpackage

//--- src/wbSramInterface.sv
`timescale 1ns/1ps

`include "sramSettings.svh"

module wbSramInterface (
	input  logic wb_clk_i,
	input  logic wb_rst_i,

	// wishbone classic slave
	input  logic wbCyc_i,
	input  logic wbStb_i,
	input  logic wbWe_i,
	input  sramPkg::byteSel_t wbSel_i,
	input  sramPkg::memAddr_t wbAdr_i,
	input  sramPkg::memData_t wbDataWrite_i,
	output logic wbAck_o,
	output logic wbStall_o,
	output logic wbErr_o,
	output sramPkg::memData_t wbDataRead_o,

	// local memory request
	output sramPkg::memAddr_t memAddress_o,
	output sramPkg::byteSel_t memByteSelect_o,
	output logic memWriteEnable_o,
	output logic memReadEnable_o,
	output sramPkg::memData_t memDataWrite_o,
	input  sramPkg::memData_t memDataRead_i,
	input  logic memBusy_i
);

	localparam logic [1:0] stateIdle  = 2'h0;
	localparam logic [1:0] stateWrite = 2'h1;
	localparam logic [1:0] stateRead  = 2'h2;

	logic [1:0] state;
	logic stall;
	logic acknowledge;
	logic error;

	sramPkg::memAddr_t currentAddress;
	sramPkg::byteSel_t currentByteSelect;
	sramPkg::memData_t currentDataWrite;
	sramPkg::memData_t readData;

	logic isStateIdle;
	logic isStateWrite;
	logic isStateRead;
	logic accept;
	logic outOfRange;
	logic memDone;

	assign isStateIdle = state == stateIdle;
	assign isStateWrite = state == stateWrite;
	assign isStateRead = state == stateRead;

	// the edge that ends a cycle still shows strobe, so skip it
	assign accept = isStateIdle && wbCyc_i && wbStb_i && !acknowledge && !error;
	assign outOfRange = |wbAdr_i[`SRAM_ADDR_WIDTH-1:`SRAM_DEPTH_LOG2];
	assign memDone = !isStateIdle && !memBusy_i; // request completes this cycle

	// --------------------
	// control FSM
	// --------------------
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state <= stateIdle;
			stall <= 1'b0;
			acknowledge <= 1'b0;
			error <= 1'b0;
		end else begin
			acknowledge <= 1'b0; // single cycle pulses
			error <= 1'b0;

			case (state)
				stateIdle: begin
					if (accept) begin
						if (outOfRange) begin
							error <= 1'b1; // no memory access
						end else begin
							stall <= 1'b1;
							state <= wbWe_i ? stateWrite : stateRead;
						end
					end
				end

				stateWrite, stateRead: begin
					if (memDone) begin
						state <= stateIdle;
						stall <= 1'b0;
						acknowledge <= 1'b1;
					end
				end

				default: begin
					state <= stateIdle;
					stall <= 1'b0;
				end
			endcase
		end
	end

	// --------------------
	// request payload
	// --------------------
	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			currentAddress <= wbAdr_i;
			currentByteSelect <= wbSel_i;
			currentDataWrite <= wbDataWrite_i;
		end

		if (isStateRead && memDone) begin
			readData <= memDataRead_i; // held for the ack cycle
		end
	end

	assign wbAck_o = acknowledge;
	assign wbStall_o = stall;
	assign wbErr_o = error;
	assign wbDataRead_o = readData;

	assign memAddress_o = currentAddress;
	assign memByteSelect_o = currentByteSelect;
	assign memDataWrite_o = currentDataWrite;
	assign memWriteEnable_o = isStateWrite;
	assign memReadEnable_o = isStateRead;

	// the master keeps cycle and strobe up for the whole access
	masterHolds: assert property (
		@(posedge wb_clk_i) disable iff (wb_rst_i)
		stall |-> (wbCyc_i && wbStb_i)
	);

	busyWhileIdle: assert property (
		@(posedge wb_clk_i) disable iff (wb_rst_i)
		isStateIdle |-> memBusy_i
	);

endmodule

//--- src/localMemoryArbiter.sv
`timescale 1ns/1ps

`include "sramSettings.svh"

module localMemoryArbiter (
	input  logic wb_clk_i,
	input  logic wb_rst_i,

	// requests from the interfaces
	input  logic [`SRAM_CORE_COUNT-1:0] reqRead_i,
	input  logic [`SRAM_CORE_COUNT-1:0] reqWrite_i,
	input  sramPkg::memAddr_t reqAddress_i [`SRAM_CORE_COUNT],
	input  sramPkg::byteSel_t reqByteSelect_i [`SRAM_CORE_COUNT],
	input  sramPkg::memData_t reqDataWrite_i [`SRAM_CORE_COUNT],
	output logic [`SRAM_CORE_COUNT-1:0] reqBusy_o,
	output sramPkg::memData_t reqDataRead_o [`SRAM_CORE_COUNT],

	// shared memory port
	input  logic memBusy_i,
	input  sramPkg::memData_t memDataRead_i,
	output logic memReadEnable_o,
	output logic memWriteEnable_o,
	output sramPkg::memAddr_t memAddress_o,
	output sramPkg::byteSel_t memByteSelect_o,
	output sramPkg::memData_t memDataWrite_o
);

	logic [`SRAM_CORE_COUNT-1:0] request;
	sramPkg::coreIdx_t owner;
	sramPkg::coreIdx_t other;
	sramPkg::coreIdx_t grant;
	logic ownerRequest; // owner was requesting last cycle
	logic locked;

	assign request = reqRead_i | reqWrite_i;
	assign other = ~owner; // two ports only
	assign locked = ownerRequest && request[owner];

	// --------------------
	// grant
	// --------------------
	always_comb begin
		grant = owner;
		if (!locked && request[other]) begin
			grant = other; // last owner loses a tie
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			owner <= '0;
			ownerRequest <= 1'b0;
		end else begin
			owner <= grant;
			ownerRequest <= request[grant];
		end
	end

	// --------------------
	// request mux
	// --------------------
	assign memReadEnable_o = reqRead_i[grant];
	assign memWriteEnable_o = reqWrite_i[grant];
	assign memAddress_o = reqAddress_i[grant];
	assign memByteSelect_o = reqByteSelect_i[grant];
	assign memDataWrite_o = reqDataWrite_i[grant];

	always_comb begin
		for (int core = 0; core < `SRAM_CORE_COUNT; core++) begin
			reqBusy_o[core] = (grant == sramPkg::coreIdx_t'(core)) ? memBusy_i : 1'b1;
			reqDataRead_o[core] = memDataRead_i; // shared read bus
		end
	end

	// a started access keeps the memory until it completes
	grantHeld: assert property (
		@(posedge wb_clk_i) disable iff (wb_rst_i)
		(request[grant] && memBusy_i) |=> (grant == $past(grant))
	);

endmodule

//--- src/localSram.sv
`timescale 1ns/1ps

`include "sramSettings.svh"

module localSram (
	input  logic wb_clk_i,
	input  logic wb_rst_i,
	input  logic memReadEnable_i,
	input  logic memWriteEnable_i,
	input  sramPkg::memAddr_t memAddress_i,
	input  sramPkg::byteSel_t memByteSelect_i,
	input  sramPkg::memData_t memDataWrite_i,
	output logic memBusy_o,
	output sramPkg::memData_t memDataRead_o
);

	localparam int depth = 1 << `SRAM_DEPTH_LOG2;
	localparam int laneWidth = `SRAM_DATA_WIDTH / `SRAM_SEL_WIDTH;
	localparam int countWidth = $clog2(`SRAM_WAIT_STATES + 2);

	sramPkg::memData_t memory [depth];
	sramPkg::memData_t readData;

	logic [`SRAM_DEPTH_LOG2-1:0] wordIndex;
	logic [countWidth-1:0] waitCount;
	logic request;
	logic complete;

	assign wordIndex = memAddress_i[`SRAM_DEPTH_LOG2-1:0]; // range checked upstream
	assign request = memReadEnable_i || memWriteEnable_i;
	assign complete = request && (waitCount == countWidth'(`SRAM_WAIT_STATES));

	assign memBusy_o = !complete;
	assign memDataRead_o = readData;

	// --------------------
	// wait states
	// --------------------
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i || !request || complete) begin
			waitCount <= '0; // next request starts over
		end else begin
			waitCount <= waitCount + 1'b1;
		end
	end

	// --------------------
	// array
	// --------------------
	always_ff @(posedge wb_clk_i) begin
		if (complete && memWriteEnable_i) begin
			for (int lane = 0; lane < `SRAM_SEL_WIDTH; lane++) begin
				if (memByteSelect_i[lane]) begin
					memory[wordIndex][lane*laneWidth +: laneWidth] <=
						memDataWrite_i[lane*laneWidth +: laneWidth];
				end
			end
		end

		if (memReadEnable_i) begin
			readData <= memory[wordIndex]; // valid once the address has been held a cycle
		end
	end

	// the read register needs the request steady until completion
	requestHeld: assert property (
		@(posedge wb_clk_i) disable iff (wb_rst_i)
		(request && !complete) |=> (request && $stable(memAddress_i))
	);

endmodule

//--- src/wbSramSubsystem.sv
`timescale 1ns/1ps

`include "sramSettings.svh"

module wbSramSubsystem (
	input  logic wb_clk_i,
	input  logic wb_rst_i,

	// one wishbone slave port per core
	input  logic [`SRAM_CORE_COUNT-1:0] wbCyc_i,
	input  logic [`SRAM_CORE_COUNT-1:0] wbStb_i,
	input  logic [`SRAM_CORE_COUNT-1:0] wbWe_i,
	input  sramPkg::byteSel_t wbSel_i [`SRAM_CORE_COUNT],
	input  sramPkg::memAddr_t wbAdr_i [`SRAM_CORE_COUNT],
	input  sramPkg::memData_t wbDataWrite_i [`SRAM_CORE_COUNT],
	output logic [`SRAM_CORE_COUNT-1:0] wbAck_o,
	output logic [`SRAM_CORE_COUNT-1:0] wbStall_o,
	output logic [`SRAM_CORE_COUNT-1:0] wbErr_o,
	output sramPkg::memData_t wbDataRead_o [`SRAM_CORE_COUNT]
);

	// --------------------
	// interface side
	// --------------------
	logic [`SRAM_CORE_COUNT-1:0] reqRead;
	logic [`SRAM_CORE_COUNT-1:0] reqWrite;
	logic [`SRAM_CORE_COUNT-1:0] reqBusy;
	sramPkg::memAddr_t reqAddress [`SRAM_CORE_COUNT];
	sramPkg::byteSel_t reqByteSelect [`SRAM_CORE_COUNT];
	sramPkg::memData_t reqDataWrite [`SRAM_CORE_COUNT];
	sramPkg::memData_t reqDataRead [`SRAM_CORE_COUNT];

	// memory side
	logic memReadEnable;
	logic memWriteEnable;
	logic memBusy;
	sramPkg::memAddr_t memAddress;
	sramPkg::byteSel_t memByteSelect;
	sramPkg::memData_t memDataWrite;
	sramPkg::memData_t memDataRead;

	for (genvar core = 0; core < `SRAM_CORE_COUNT; core++) begin : gPort
		wbSramInterface port_i (
			.wb_clk_i         (wb_clk_i),
			.wb_rst_i         (wb_rst_i),
			.wbCyc_i          (wbCyc_i[core]),
			.wbStb_i          (wbStb_i[core]),
			.wbWe_i           (wbWe_i[core]),
			.wbSel_i          (wbSel_i[core]),
			.wbAdr_i          (wbAdr_i[core]),
			.wbDataWrite_i    (wbDataWrite_i[core]),
			.wbAck_o          (wbAck_o[core]),
			.wbStall_o        (wbStall_o[core]),
			.wbErr_o          (wbErr_o[core]),
			.wbDataRead_o     (wbDataRead_o[core]),
			.memAddress_o     (reqAddress[core]),
			.memByteSelect_o  (reqByteSelect[core]),
			.memWriteEnable_o (reqWrite[core]),
			.memReadEnable_o  (reqRead[core]),
			.memDataWrite_o   (reqDataWrite[core]),
			.memDataRead_i    (reqDataRead[core]),
			.memBusy_i        (reqBusy[core])
		);
	end

	localMemoryArbiter arbiter_i (
		.wb_clk_i         (wb_clk_i),
		.wb_rst_i         (wb_rst_i),
		.reqRead_i        (reqRead),
		.reqWrite_i       (reqWrite),
		.reqAddress_i     (reqAddress),
		.reqByteSelect_i  (reqByteSelect),
		.reqDataWrite_i   (reqDataWrite),
		.reqBusy_o        (reqBusy),
		.reqDataRead_o    (reqDataRead),
		.memBusy_i        (memBusy),
		.memDataRead_i    (memDataRead),
		.memReadEnable_o  (memReadEnable),
		.memWriteEnable_o (memWriteEnable),
		.memAddress_o     (memAddress),
		.memByteSelect_o  (memByteSelect),
		.memDataWrite_o   (memDataWrite)
	);

	localSram sram_i (
		.wb_clk_i         (wb_clk_i),
		.wb_rst_i         (wb_rst_i),
		.memReadEnable_i  (memReadEnable),
		.memWriteEnable_i (memWriteEnable),
		.memAddress_i     (memAddress),
		.memByteSelect_i  (memByteSelect),
		.memDataWrite_i   (memDataWrite),
		.memBusy_o        (memBusy),
		.memDataRead_o    (memDataRead)
	);

endmodule

//--- dv/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o; // 10 ns period
	end

	initial begin
		rst_o = 1'b1;
		repeat (2) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

//--- dv/wbSramSubsystem_tb.sv
`timescale 1ns/1ps

`include "sramSettings.svh"

module wbSramSubsystem_tb;

	localparam int timeoutCycles = 50;

	logic clk;
	logic rst;

	logic [`SRAM_CORE_COUNT-1:0] wbCyc;
	logic [`SRAM_CORE_COUNT-1:0] wbStb;
	logic [`SRAM_CORE_COUNT-1:0] wbWe;
	sramPkg::byteSel_t wbSel [`SRAM_CORE_COUNT];
	sramPkg::memAddr_t wbAdr [`SRAM_CORE_COUNT];
	sramPkg::memData_t wbDataWrite [`SRAM_CORE_COUNT];
	logic [`SRAM_CORE_COUNT-1:0] wbAck;
	logic [`SRAM_CORE_COUNT-1:0] wbStall;
	logic [`SRAM_CORE_COUNT-1:0] wbErr;
	sramPkg::memData_t wbDataRead [`SRAM_CORE_COUNT];

	// one entry per vector line
	string vecName [$];
	int vecPort [$];
	bit vecWrite [$];
	bit vecConcurrent [$];
	sramPkg::memAddr_t vecAddr [$];
	sramPkg::byteSel_t vecSel [$];
	sramPkg::memData_t vecData [$];
	sramPkg::memData_t vecExpData [$];
	logic vecExpErr [$];

	integer seed;
	int gap;
	int idx;
	int dataErrors;
	int errFlagErrors;
	int ackErrors;
	int latencyErrors;
	int otherErrors;

	tbClock clock_i (
		.clk_o (clk),
		.rst_o (rst)
	);

	wbSramSubsystem dut_i (
		.wb_clk_i      (clk),
		.wb_rst_i      (rst),
		.wbCyc_i       (wbCyc),
		.wbStb_i       (wbStb),
		.wbWe_i        (wbWe),
		.wbSel_i       (wbSel),
		.wbAdr_i       (wbAdr),
		.wbDataWrite_i (wbDataWrite),
		.wbAck_o       (wbAck),
		.wbStall_o     (wbStall),
		.wbErr_o       (wbErr),
		.wbDataRead_o  (wbDataRead)
	);

	// --------------------
	// compare tasks
	// --------------------
	task automatic checkData(input string name, input sramPkg::memData_t expected,
		input sramPkg::memData_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: read data expected %h, actual %h", name, expected, actual);
			dataErrors++;
		end
	endtask

	task automatic checkErr(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s: error pulse expected %b, actual %b", name, expected, actual);
			errFlagErrors++;
		end
	endtask

	task automatic checkAckCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("ERROR %s: acknowledges expected %0d, actual %0d", name, expected, actual);
			ackErrors++;
		end
	endtask

	task automatic checkLatency(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("ERROR %s: latency expected %0d, actual %0d", name, expected, actual);
			latencyErrors++;
		end
	endtask

	// --------------------
	// vector file
	// --------------------
	task automatic readVectors();
		int fd;
		int got;
		int fields;
		int port;
		int concurrent;
		int expErr;
		string line;
		string name;
		string op;
		sramPkg::memAddr_t addr;
		sramPkg::byteSel_t sel;
		sramPkg::memData_t data;
		sramPkg::memData_t expData;

		fd = $fopen("dv/sramVectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file dv/sramVectors.txt");
			otherErrors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				got = $fgets(line, fd);
				if (got > 1 && line.substr(0, 0) != "#") begin
					fields = $sscanf(line, "%s %d %s %d %h %h %h %h %d", name, port, op,
						concurrent, addr, sel, data, expData, expErr);
					if (fields != 9 || port < 0 || port >= `SRAM_CORE_COUNT) begin
						$display("malformed vector line: %s", line);
						otherErrors++;
					end else begin
						vecName.push_back(name);
						vecPort.push_back(port);
						vecWrite.push_back(op == "W");
						vecConcurrent.push_back(concurrent != 0);
						vecAddr.push_back(addr);
						vecSel.push_back(sel);
						vecData.push_back(data);
						vecExpData.push_back(expData);
						vecExpErr.push_back(expErr != 0);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// --------------------
	// bus activity
	// --------------------
	task automatic waitForReset();
		int cycles;

		cycles = 0;
		while (rst && cycles < 20) begin
			@(posedge clk);
			cycles++;
		end
		if (rst) begin
			$display("reset was never released");
			otherErrors++;
		end
		@(negedge clk);
	endtask

	task automatic checkIdleOutputs();
		for (int port = 0; port < `SRAM_CORE_COUNT; port++) begin
			if (wbAck[port] !== 1'b0 || wbStall[port] !== 1'b0 || wbErr[port] !== 1'b0) begin
				$display("ERROR afterReset: port %0d ack/stall/err expected 000, actual %b%b%b",
					port, wbAck[port], wbStall[port], wbErr[port]);
				otherErrors++;
			end
		end
	endtask

	// timed is set for an access that has the memory to itself
	task automatic runAccess(input int vec, input bit timed);
		string name;
		int port;
		int waited;
		int acks;
		int errs;
		bit done;
		bit stallOk;
		logic expErr;
		sramPkg::memData_t readValue;

		name = vecName[vec];
		port = vecPort[vec];
		expErr = vecExpErr[vec];
		readValue = '0;

		@(posedge clk);
		wbCyc[port] <= 1'b1;
		wbStb[port] <= 1'b1;
		wbWe[port] <= vecWrite[vec];
		wbSel[port] <= vecSel[vec];
		wbAdr[port] <= vecAddr[vec];
		wbDataWrite[port] <= vecData[vec];

		waited = 0;
		acks = 0;
		errs = 0;
		done = 1'b0;
		stallOk = 1'b1;
		while (!done && waited < timeoutCycles) begin
			@(negedge clk);
			waited++;
			if (wbAck[port]) begin
				acks++;
				readValue = wbDataRead[port];
			end
			if (wbErr[port]) errs++;
			if (wbAck[port] || wbErr[port]) begin
				done = 1'b1;
			end else if (waited >= 2 && !wbStall[port]) begin
				stallOk = 1'b0; // accepted one edge after the strobe
			end
		end

		if (!done) begin
			$display("timeout: %s on port %0d saw no ack or error in %0d cycles",
				name, port, timeoutCycles);
			otherErrors++;
		end

		@(posedge clk);
		wbCyc[port] <= 1'b0;
		wbStb[port] <= 1'b0;
		wbWe[port] <= 1'b0;
		@(negedge clk);
		if (wbAck[port]) acks++; // a second pulse would show here
		if (wbErr[port]) errs++;

		checkErr(name, expErr, errs != 0);
		if (errs > 1) begin
			$display("%s gave more than one error pulse", name);
			otherErrors++;
		end
		checkAckCount(name, expErr ? 0 : 1, acks);
		if (!expErr && !vecWrite[vec]) checkData(name, vecExpData[vec], readValue);
		if (!expErr && !stallOk) begin
			$display("%s: stall fell before the acknowledge", name);
			otherErrors++;
		end
		if (timed && done) checkLatency(name, expErr ? 1 : `SRAM_WAIT_STATES + 2, waited - 1);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		wbCyc = '0;
		wbStb = '0;
		wbWe = '0;
		for (int port = 0; port < `SRAM_CORE_COUNT; port++) begin
			wbSel[port] = '0;
			wbAdr[port] = '0;
			wbDataWrite[port] = '0;
		end
		seed = 32'h946e_aa3e;
		dataErrors = 0;
		errFlagErrors = 0;
		ackErrors = 0;
		latencyErrors = 0;
		otherErrors = 0;

		readVectors();
		waitForReset();
		checkIdleOutputs();

		idx = 0;
		while (idx < vecName.size()) begin
			gap = $random(seed) & 32'h3;
			repeat (gap) @(posedge clk);
			if (vecConcurrent[idx] && idx + 1 < vecName.size()) begin
				fork
					runAccess(idx, 1'b0);
					runAccess(idx + 1, 1'b0);
				join
				idx += 2;
			end else begin
				runAccess(idx, 1'b1);
				idx++;
			end
		end

		$display("errors: data %0d, error flag %0d, ack count %0d, latency %0d, other %0d",
			dataErrors, errFlagErrors, ackErrors, latencyErrors, otherErrors);
		if (dataErrors + errFlagErrors + ackErrors + latencyErrors + otherErrors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- dv/sramVectors.txt
# name port op(W/R) concurrent addr sel wdata expRead expErr, all numbers but port in hex
# concurrent 1 issues the line on the same edge as the next one
wrFull0     0 W 0 000010 f 11223344 00000000 0
rdFull0     0 R 0 000010 f 00000000 11223344 0
rdCross1    1 R 0 000010 f 00000000 11223344 0
wrFull1     1 W 0 000020 f a5a5a5a5 00000000 0
rdCross0    0 R 0 000020 f 00000000 a5a5a5a5 0
wrLane0     0 W 0 000010 1 000000ee 00000000 0
rdLane0     1 R 0 000010 f 00000000 112233ee 0
wrLane23    1 W 0 000010 c 99880000 00000000 0
rdLane23    0 R 0 000010 f 00000000 998833ee 0
wrLane1     0 W 0 000020 2 00007700 00000000 0
rdLane1     0 R 0 000020 f 00000000 a5a577a5 0
wrNoLane    1 W 0 000020 0 ffffffff 00000000 0
rdNoLane    1 R 0 000020 f 00000000 a5a577a5 0
wrZero      0 W 0 000000 f cafef00d 00000000 0
wrOutFirst  0 W 0 000400 f deadbeef 00000000 1
rdZero0     0 R 0 000000 f 00000000 cafef00d 0
rdOutHigh   1 R 0 800000 f 00000000 00000000 1
wrOutTop    1 W 0 fffc00 f 0badc0de 00000000 1
rdZero1     1 R 0 000000 f 00000000 cafef00d 0
wrTop       1 W 0 0003ff f 0f0f0f0f 00000000 0
rdTop       0 R 0 0003ff f 00000000 0f0f0f0f 0
wrOutAlias  0 W 0 0007ff f 12345678 00000000 1
rdTopAgain  1 R 0 0003ff f 00000000 0f0f0f0f 0
cWr0        0 W 1 000100 f 01010101 00000000 0
cWr1        1 W 0 000101 f 02020202 00000000 0
cRd0        0 R 1 000101 f 00000000 02020202 0
cRd1        1 R 0 000100 f 00000000 01010101 0
cSame0      0 R 1 000010 f 00000000 998833ee 0
cSame1      1 R 0 000010 f 00000000 998833ee 0
cErr0       0 W 1 000500 f 55555555 00000000 1
cWr1b       1 W 0 000102 f 0c0c0c0c 00000000 0
cPart0      0 W 1 000101 3 0000abcd 00000000 0
cRdA1       1 R 0 000102 f 00000000 0c0c0c0c 0
cRdB0       0 R 1 000101 f 00000000 0202abcd 0
cErr1       1 R 0 000900 f 00000000 00000000 1
cRd0c       0 R 1 000100 f 00000000 01010101 0
cRd1c       1 R 0 000102 f 00000000 0c0c0c0c 0
rdLast      1 R 0 000100 f 00000000 01010101 0

//--- files.f
+incdir+src
src/sramPkg.sv
src/wbSramInterface.sv
src/localMemoryArbiter.sv
src/localSram.sv
src/wbSramSubsystem.sv
dv/tbClock.sv
dv/wbSramSubsystem_tb.sv
